// File: verilog/core_types_pkg.sv
// ================================================
// Core-wide address types
// ================================================

`default_nettype none

package core_types_pkg;

    // instruction address.
    typedef logic [31:0] addr_t;

    // fixed instruction size in bytes.
    // also sets the low PC bits left out of table indices.
    localparam int INST_BYTES = 4;

endpackage

`default_nettype wire

// File: verilog/bpu_types_pkg.sv
// ================================================
// Branch predictor counter types
// ================================================

`default_nettype none

package bpu_types_pkg;

    // two-bit saturating branch counter.
    typedef logic [1:0] ctr_t;

    // saturation limits.
    localparam ctr_t CTR_MAX = 2'b11;
    localparam ctr_t CTR_MIN = 2'b00;

    // weakly not taken, written by the clearing sweep.
    localparam ctr_t CTR_INIT = 2'b01;

endpackage

`default_nettype wire

// File: verilog/bpu_bram.sv
// ================================================
// Simple dual-port block RAM
// ================================================

`default_nettype none

module bpu_bram #(
    parameter int DATA_WIDTH = 2,
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    output logic [DATA_WIDTH-1:0] rd_data_o,
    input  logic                  wr_en_i,
    input  logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [DATA_WIDTH-1:0] wr_data_i
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // registered read, old data wins on a clash.
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/bpu_table_init.sv
// ================================================
// Post-reset table clearing sweep
// ================================================

`default_nettype none

module bpu_table_init #(
    parameter int PHT_DEPTH_EXP2 = 6,
    parameter int BTB_DEPTH_EXP2 = 4,
    localparam int INDEX_WIDTH =
        (PHT_DEPTH_EXP2 > BTB_DEPTH_EXP2) ? PHT_DEPTH_EXP2 : BTB_DEPTH_EXP2
) (
    input  logic                   clk,
    input  logic                   rst_i,
    output logic                   init_active_o,
    output logic [INDEX_WIDTH-1:0] init_index_o
);

    typedef enum logic {
        INIT_CLEAR,
        INIT_READY
    } init_state_t;

    init_state_t            state;
    logic [INDEX_WIDTH-1:0] index;

    // walk every address once, then stay ready until reset.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= INIT_CLEAR;
            index <= '0;
        end else if (state == INIT_CLEAR) begin
            index <= index + 1'b1;
            if (&index) begin
                state <= INIT_READY;
            end
        end
    end

    assign init_active_o = (state == INIT_CLEAR);
    assign init_index_o  = index;

endmodule

`default_nettype wire

// File: verilog/base_predictor.sv
// ================================================
// Bimodal counter table
// ================================================

`default_nettype none

module base_predictor #(
    parameter int PHT_DEPTH_EXP2 = 6,
    parameter int INIT_WIDTH     = 6
) (
    input  logic                       clk,
    input  core_types_pkg::addr_t      query_pc_i,
    output logic                       taken_o,
    output bpu_types_pkg::ctr_t        ctr_o,
    input  logic                       update_valid_i,
    input  core_types_pkg::addr_t      update_pc_i,
    input  bpu_types_pkg::ctr_t        update_ctr_i,
    input  logic                       update_taken_i,
    input  logic                       init_active_i,
    input  logic [INIT_WIDTH-1:0]      init_index_i
);

    import core_types_pkg::*;
    import bpu_types_pkg::*;

    localparam int PC_OFFSET = $clog2(INST_BYTES);

    logic [PHT_DEPTH_EXP2-1:0] query_index;
    logic [PHT_DEPTH_EXP2-1:0] update_index;
    ctr_t                      next_ctr;
    logic                      wr_en;
    logic [PHT_DEPTH_EXP2-1:0] wr_addr;
    ctr_t                      wr_data;

    assign query_index  = query_pc_i[PC_OFFSET +: PHT_DEPTH_EXP2];
    assign update_index = update_pc_i[PC_OFFSET +: PHT_DEPTH_EXP2];

    // saturating step from the counter seen at prediction time.
    always_comb begin
        if (update_taken_i) begin
            next_ctr = (update_ctr_i == CTR_MAX) ? CTR_MAX : update_ctr_i + 1'b1;
        end else begin
            next_ctr = (update_ctr_i == CTR_MIN) ? CTR_MIN : update_ctr_i - 1'b1;
        end
    end

    // sweep owns the write port while clearing.
    assign wr_en   = init_active_i | update_valid_i;
    assign wr_addr = init_active_i ? init_index_i[PHT_DEPTH_EXP2-1:0] : update_index;
    assign wr_data = init_active_i ? CTR_INIT : next_ctr;

    bpu_bram #(
        .DATA_WIDTH($bits(ctr_t)),
        .ADDR_WIDTH(PHT_DEPTH_EXP2)
    ) pht_ram (
        .clk      (clk),
        .rd_addr_i(query_index),
        .rd_data_o(ctr_o),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data)
    );

    assign taken_o = ctr_o[$bits(ctr_t)-1];

endmodule

`default_nettype wire

// File: verilog/branch_target_buffer.sv
// ================================================
// Direct-mapped branch target buffer
// ================================================

`default_nettype none

module branch_target_buffer #(
    parameter int BTB_DEPTH_EXP2 = 4,
    parameter int INIT_WIDTH     = 6
) (
    input  logic                  clk,
    input  core_types_pkg::addr_t query_pc_i,
    output logic                  hit_o,
    output core_types_pkg::addr_t target_o,
    input  logic                  update_valid_i,
    input  core_types_pkg::addr_t update_pc_i,
    input  logic                  update_taken_i,
    input  core_types_pkg::addr_t update_target_i,
    input  logic                  init_active_i,
    input  logic [INIT_WIDTH-1:0] init_index_i
);

    import core_types_pkg::*;

    localparam int PC_OFFSET   = $clog2(INST_BYTES);
    localparam int TAG_WIDTH   = $bits(addr_t) - PC_OFFSET - BTB_DEPTH_EXP2;
    localparam int ENTRY_WIDTH = 1 + TAG_WIDTH + $bits(addr_t);

    logic [BTB_DEPTH_EXP2-1:0] query_index;
    logic [BTB_DEPTH_EXP2-1:0] update_index;
    logic [TAG_WIDTH-1:0]      query_tag;
    logic [TAG_WIDTH-1:0]      query_tag_q;
    logic [TAG_WIDTH-1:0]      update_tag;
    logic                      wr_en;
    logic [BTB_DEPTH_EXP2-1:0] wr_addr;
    logic [ENTRY_WIDTH-1:0]    wr_data;
    logic [ENTRY_WIDTH-1:0]    rd_entry;
    logic                      rd_valid;
    logic [TAG_WIDTH-1:0]      rd_tag;

    assign query_index  = query_pc_i[PC_OFFSET +: BTB_DEPTH_EXP2];
    assign update_index = update_pc_i[PC_OFFSET +: BTB_DEPTH_EXP2];
    assign query_tag    = query_pc_i[$bits(addr_t)-1 -: TAG_WIDTH];
    assign update_tag   = update_pc_i[$bits(addr_t)-1 -: TAG_WIDTH];

    // only taken branches allocate; clearing writes invalid entries.
    assign wr_en   = init_active_i | (update_valid_i & update_taken_i);
    assign wr_addr = init_active_i ? init_index_i[BTB_DEPTH_EXP2-1:0] : update_index;
    assign wr_data = init_active_i ? '0 : {1'b1, update_tag, update_target_i};

    bpu_bram #(
        .DATA_WIDTH(ENTRY_WIDTH),
        .ADDR_WIDTH(BTB_DEPTH_EXP2)
    ) btb_ram (
        .clk      (clk),
        .rd_addr_i(query_index),
        .rd_data_o(rd_entry),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data)
    );

    // tag lines up with the RAM output.
    always_ff @(posedge clk) begin
        query_tag_q <= query_tag;
    end

    assign {rd_valid, rd_tag, target_o} = rd_entry;
    assign hit_o = rd_valid & (rd_tag == query_tag_q);

endmodule

`default_nettype wire

// File: verilog/bpu_top.sv
// ================================================
// Branch prediction unit top
// ================================================

`default_nettype none

module bpu_top #(
    parameter int PHT_DEPTH_EXP2 = 6,
    parameter int BTB_DEPTH_EXP2 = 4
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  query_valid_i,
    input  core_types_pkg::addr_t query_pc_i,
    input  logic                  upd_valid_i,
    input  core_types_pkg::addr_t upd_pc_i,
    input  bpu_types_pkg::ctr_t   upd_ctr_i,
    input  logic                  upd_taken_i,
    input  core_types_pkg::addr_t upd_target_i,
    output logic                  ready_o,
    output logic                  pred_valid_o,
    output logic                  pred_taken_o,
    output bpu_types_pkg::ctr_t   pred_ctr_o,
    output core_types_pkg::addr_t pred_pc_o
);

    import core_types_pkg::*;

    localparam int INIT_WIDTH =
        (PHT_DEPTH_EXP2 > BTB_DEPTH_EXP2) ? PHT_DEPTH_EXP2 : BTB_DEPTH_EXP2;

    logic                  init_active;
    logic [INIT_WIDTH-1:0] init_index;
    logic                  upd_accept;
    addr_t                 query_pc_q;
    logic                  btb_hit;
    addr_t                 btb_target;

    bpu_table_init #(
        .PHT_DEPTH_EXP2(PHT_DEPTH_EXP2),
        .BTB_DEPTH_EXP2(BTB_DEPTH_EXP2)
    ) table_init (
        .clk          (clk),
        .rst_i        (rst_i),
        .init_active_o(init_active),
        .init_index_o (init_index)
    );

    assign ready_o    = ~init_active;
    assign upd_accept = upd_valid_i & ready_o;

    base_predictor #(
        .PHT_DEPTH_EXP2(PHT_DEPTH_EXP2),
        .INIT_WIDTH    (INIT_WIDTH)
    ) pht (
        .clk           (clk),
        .query_pc_i    (query_pc_i),
        .taken_o       (pred_taken_o),
        .ctr_o         (pred_ctr_o),
        .update_valid_i(upd_accept),
        .update_pc_i   (upd_pc_i),
        .update_ctr_i  (upd_ctr_i),
        .update_taken_i(upd_taken_i),
        .init_active_i (init_active),
        .init_index_i  (init_index)
    );

    branch_target_buffer #(
        .BTB_DEPTH_EXP2(BTB_DEPTH_EXP2),
        .INIT_WIDTH    (INIT_WIDTH)
    ) btb (
        .clk            (clk),
        .query_pc_i     (query_pc_i),
        .hit_o          (btb_hit),
        .target_o       (btb_target),
        .update_valid_i (upd_accept),
        .update_pc_i    (upd_pc_i),
        .update_taken_i (upd_taken_i),
        .update_target_i(upd_target_i),
        .init_active_i  (init_active),
        .init_index_i   (init_index)
    );

    // valid only for queries taken while ready.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= query_valid_i & ready_o;
        end
    end

    always_ff @(posedge clk) begin
        query_pc_q <= query_pc_i;
    end

    // buffered target only on a taken prediction that hits.
    assign pred_pc_o = (pred_taken_o & btb_hit) ? btb_target
                                                : query_pc_q + addr_t'(INST_BYTES);

endmodule

`default_nettype wire

// File: verif/bpu_asserts.sv
// ================================================
// Port checks for the prediction unit
// ================================================

`default_nettype none

module bpu_asserts (
    input logic clk,
    input logic rst_i,
    input logic query_valid_i,
    input logic ready_i,
    input logic pred_valid_i
);

    // failed checks so far.
    int unsigned fail_count = 0;

    // a prediction follows an accepted query by one cycle.
    valid_follows_query: assert property (
        @(posedge clk) disable iff (rst_i)
        ready_i |=> (pred_valid_i == $past(query_valid_i))
    ) else begin
        fail_count++;
        $error("pred_valid_o does not follow query_valid_i while ready");
    end

    // no prediction during the clearing sweep.
    no_valid_before_ready: assert property (
        @(posedge clk) disable iff (rst_i)
        !ready_i |=> !pred_valid_i
    ) else begin
        fail_count++;
        $error("pred_valid_o high after a cycle with ready_o low");
    end

    // ready only drops on reset.
    ready_stays_high: assert property (
        @(posedge clk) $fell(ready_i) |-> $past(rst_i)
    ) else begin
        fail_count++;
        $error("ready_o fell without reset");
    end

endmodule

`default_nettype wire

// File: verif/bpu_tb.sv
// ================================================
// Branch prediction unit testbench
// ================================================

`default_nettype none

module bpu_tb;

    import core_types_pkg::*;
    import bpu_types_pkg::*;

    localparam int PHT_EXP       = 6;
    localparam int BTB_EXP       = 4;
    localparam int PHT_DEPTH     = 2 ** PHT_EXP;
    localparam int BTB_DEPTH     = 2 ** BTB_EXP;
    localparam int PC_SHIFT      = $clog2(INST_BYTES);
    localparam int READY_TIMEOUT = PHT_DEPTH;

    logic  clk = 1'b0;
    logic  rst_i;
    logic  query_valid_i;
    addr_t query_pc_i;
    logic  upd_valid_i;
    addr_t upd_pc_i;
    ctr_t  upd_ctr_i;
    logic  upd_taken_i;
    addr_t upd_target_i;
    logic  ready_o;
    logic  pred_valid_o;
    logic  pred_taken_o;
    ctr_t  pred_ctr_o;
    addr_t pred_pc_o;

    // reference model of both tables.
    ctr_t  model_ctr [PHT_DEPTH];
    logic  model_btb_valid [BTB_DEPTH];
    addr_t model_btb_tag [BTB_DEPTH];
    addr_t model_btb_target [BTB_DEPTH];

    // expectation for the query issued one step earlier.
    logic   pend_valid;
    ctr_t   pend_ctr;
    addr_t  pend_pc;
    integer seed = 32'h4181_dcc6;

    bpu_top dut (.*);

    bind bpu_top bpu_asserts assert_checks (
        .clk          (clk),
        .rst_i        (rst_i),
        .query_valid_i(query_valid_i),
        .ready_i      (ready_o),
        .pred_valid_i (pred_valid_o)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (dut.assert_checks.fail_count != 0) begin
            $display("a concurrent assertion on the DUT ports failed");
            $display("RESULT: FAIL");
            $fatal(1, "assertion failure");
        end
    end

    task automatic report_mismatch(input string name, input addr_t expected,
                                   input addr_t actual);
        $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        $display("RESULT: FAIL");
        $fatal(1, "prediction mismatch");
    endtask

    function automatic ctr_t next_count(input ctr_t ctr, input logic taken);
        if (taken && ctr != CTR_MAX) begin
            return ctr + 1'b1;
        end
        if (!taken && ctr != CTR_MIN) begin
            return ctr - 1'b1;
        end
        return ctr;
    endfunction

    function automatic addr_t expected_pc(input addr_t pc, input ctr_t ctr);
        int b;
        b = int'((pc >> PC_SHIFT) % BTB_DEPTH);
        if (ctr[1] && model_btb_valid[b] && model_btb_tag[b] == (pc >> (PC_SHIFT + BTB_EXP))) begin
            return model_btb_target[b];
        end
        return pc + INST_BYTES;
    endfunction

    // small pool with aliases in both index and tag.
    function automatic addr_t pool_pc(input int r);
        return 32'h0000_4000 + (r[2:0] << PC_SHIFT) + (r[3] ? 32'h0000_0400 : 32'h0);
    endfunction

    task automatic check_prediction();
        assert (pred_valid_o === 1'b1)
            else report_mismatch("pred_valid_o", 1, pred_valid_o);
        assert (pred_taken_o === pend_ctr[1])
            else report_mismatch("pred_taken_o", pend_ctr[1], pred_taken_o);
        assert (pred_ctr_o === pend_ctr)
            else report_mismatch("pred_ctr_o", pend_ctr, pred_ctr_o);
        assert (pred_pc_o === pend_pc)
            else report_mismatch("pred_pc_o", pend_pc, pred_pc_o);
    endtask

    // one cycle of traffic; checks the previous cycle's query.
    task automatic step(input logic qv, input addr_t qpc, input logic uv,
                        input addr_t upc, input logic utaken, input addr_t utarget);
        int    u_pht;
        int    u_btb;
        ctr_t  q_ctr;
        ctr_t  u_ctr;
        addr_t next_pc;
        u_pht = int'((upc >> PC_SHIFT) % PHT_DEPTH);
        u_btb = int'((upc >> PC_SHIFT) % BTB_DEPTH);
        q_ctr = model_ctr[int'((qpc >> PC_SHIFT) % PHT_DEPTH)];
        u_ctr = model_ctr[u_pht];
        @(posedge clk);
        query_valid_i <= qv;
        query_pc_i    <= qpc;
        upd_valid_i   <= uv;
        upd_pc_i      <= upc;
        upd_ctr_i     <= u_ctr;
        upd_taken_i   <= utaken;
        upd_target_i  <= utarget;
        // the query still sees the table before this update.
        next_pc = expected_pc(qpc, q_ctr);
        if (uv) begin
            model_ctr[u_pht] = next_count(u_ctr, utaken);
            if (utaken) begin
                model_btb_valid[u_btb]  = 1'b1;
                model_btb_tag[u_btb]    = upc >> (PC_SHIFT + BTB_EXP);
                model_btb_target[u_btb] = utarget;
            end
        end
        @(negedge clk);
        if (pend_valid) begin
            check_prediction();
        end
        pend_valid = qv;
        pend_ctr   = q_ctr;
        pend_pc    = next_pc;
    endtask

    initial begin
        int wait_cycles;
        rst_i         <= 1'b1;
        query_valid_i <= 1'b0;
        query_pc_i    <= '0;
        upd_valid_i   <= 1'b0;
        upd_pc_i      <= '0;
        upd_ctr_i     <= '0;
        upd_taken_i   <= 1'b0;
        upd_target_i  <= '0;
        pend_valid = 1'b0;
        for (int i = 0; i < PHT_DEPTH; i++) begin
            model_ctr[i] = CTR_INIT;
        end
        for (int i = 0; i < BTB_DEPTH; i++) begin
            model_btb_valid[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;

        // queries during the sweep.
        wait_cycles = 0;
        while (ready_o !== 1'b1) begin
            @(posedge clk);
            query_valid_i <= 1'b1;
            query_pc_i    <= pool_pc($random(seed));
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > READY_TIMEOUT) begin
                $display("ready_o did not rise after the clearing sweep");
                $display("RESULT: FAIL");
                $fatal(1, "ready timeout");
            end
        end

        // cleared entry.
        step(1'b1, 32'h0000_2000, 1'b0, '0, 1'b0, '0);
        // walk up to saturation, then down, query and update colliding.
        repeat (3) step(1'b1, 32'h0000_2010, 1'b1, 32'h0000_2010, 1'b1, 32'h0000_8000);
        repeat (4) step(1'b1, 32'h0000_2010, 1'b1, 32'h0000_2010, 1'b0, '0);
        step(1'b1, 32'h0000_2010, 1'b0, '0, 1'b0, '0);
        // target hit, then a different tag on the same index.
        repeat (2) step(1'b0, '0, 1'b1, 32'h0000_3024, 1'b1, 32'h0000_9abc);
        step(1'b1, 32'h0000_3024, 1'b0, '0, 1'b0, '0);
        step(1'b1, 32'h0001_3024, 1'b0, '0, 1'b0, '0);
        // random back-to-back traffic.
        repeat (300) begin
            step($random(seed) & 1, pool_pc($random(seed)), $random(seed) & 1,
                 pool_pc($random(seed)), $random(seed) & 1, addr_t'($random(seed)));
        end
        step(1'b0, '0, 1'b0, '0, 1'b0, '0);

        if (dut.assert_checks.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "assertion failure at end of run");
        end
    end

endmodule

`default_nettype wire

// File: flist.f
verilog/core_types_pkg.sv
verilog/bpu_types_pkg.sv
verilog/bpu_bram.sv
verilog/bpu_table_init.sv
verilog/base_predictor.sv
verilog/branch_target_buffer.sv
verilog/bpu_top.sv
verif/bpu_asserts.sv
verif/bpu_tb.sv

// File: Bender.yml
package:
  name: bpu

sources:
  - files:
      - verilog/core_types_pkg.sv
      - verilog/bpu_types_pkg.sv
      - verilog/bpu_bram.sv
      - verilog/bpu_table_init.sv
      - verilog/base_predictor.sv
      - verilog/branch_target_buffer.sv
      - verilog/bpu_top.sv
  - target: test
    files:
      - verif/bpu_asserts.sv
      - verif/bpu_tb.sv
